/* rtl/ru_avl_pkg.sv */
// Avalon-MM CSR port dimensions and default command timing for the
// remote-update controller. Imported by modules that size Avalon-side signals.

package ru_avl_pkg;

   // Avalon data bus width
   localparam int AVL_DATA_W = 32;

   // CSR word address
   // Upper 3 bits pick the register, lower 2 bits refine it
   localparam int AVL_ADDR_W = 5;

   // Idle cycles forced after every command handed to the core
   // Covers the core's latency in raising busy, and gives direct
   // control strobes time to settle
   localparam int DEFAULT_HOLD_CYCLES = 2;

endpackage : ru_avl_pkg

/* rtl/ru_csr_pkg.sv */
// CSR register map of the remote-update block, the parameter codes the core
// expects, and the two-way decode of the CSR address word. Imported by the
// command pipeline, the issue logic and the top level.

package ru_csr_pkg;

   // Register index, upper 3 bits of the CSR address
   localparam logic [2:0] CSR_STATE_MODE      = 3'd0;
   localparam logic [2:0] CSR_EARLY_CONF_DONE = 3'd1;
   localparam logic [2:0] CSR_WD_TIMEOUT      = 3'd2;
   localparam logic [2:0] CSR_WD_ENABLE       = 3'd3;
   localparam logic [2:0] CSR_BOOT_ADDRESS    = 3'd4;
   localparam logic [2:0] CSR_INTERNAL_OSC    = 3'd5;
   localparam logic [2:0] CSR_TRIGGER_COND    = 3'd6;
   localparam logic [2:0] CSR_CONTROL         = 3'd7;

   // Operation select inside CSR_CONTROL
   localparam logic [1:0] CTRL_RESET_TIMER = 2'd0;
   localparam logic [1:0] CTRL_RECONFIG    = 2'd1;

   // Parameter code on the core's ru_param bus
   typedef logic [2:0] ru_param_t;

   // Same address word, two readings
   // Parameter registers use the low bits as read source,
   // CSR_CONTROL uses them as operation select
   typedef union packed {
      struct packed {
         logic [2:0] index;
         logic [1:0] read_source;
      } param;
      struct packed {
         logic [2:0] index;
         logic [1:0] control_op;
      } ctrl;
   } ru_addr_u;

   // CSR index to core parameter code
   // Code 5 is unused by this register map
   function automatic ru_param_t csr_to_param(input logic [2:0] index);
      ru_param_t code;
      case (index)
         CSR_INTERNAL_OSC: code = 3'd6;
         CSR_TRIGGER_COND: code = 3'd7;
         // Not a parameter register, code is don't care
         CSR_CONTROL:      code = 3'd0;
         default:          code = index;
      endcase
      return code;
   endfunction

endpackage : ru_csr_pkg

/* rtl/avl_cmd_pipeline.sv */
// Avalon-MM CSR front end. Accepts transfers under a registered waitrequest,
// parks a request caught by a rising waitrequest in a skid register, holds the
// current command in a one-entry stage and strobes cmd_issue when it may go
// to the core. A short hold follows every issue.

`timescale 1ns/1ps

module avl_cmd_pipeline
   import ru_avl_pkg::*;
   import ru_csr_pkg::*;
#(
   parameter int HOLD_CYCLES = DEFAULT_HOLD_CYCLES
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  avl_csr_read,
   input  logic                  avl_csr_write,
   input  logic [AVL_ADDR_W-1:0] avl_csr_addr,
   input  logic [AVL_DATA_W-1:0] avl_csr_wdata,
   input  logic                  busy_stall,
   output logic                  avl_csr_waitrequest,
   output logic                  cmd_read,
   output logic                  cmd_write,
   output ru_addr_u              cmd_addr,
   output logic [AVL_DATA_W-1:0] cmd_wdata,
   output logic                  cmd_issue
);

   // Hold counter sized to reach HOLD_CYCLES, at least one bit
   localparam int CNT_W = (HOLD_CYCLES > 0) ? $clog2(HOLD_CYCLES + 1) : 1;

   // Skid register
   logic                  skid_read;
   logic                  skid_write;
   logic [AVL_ADDR_W-1:0] skid_addr;
   logic [AVL_DATA_W-1:0] skid_wdata;
   logic                  use_skid;

   // Stage input mux
   logic                  load_read;
   logic                  load_write;
   logic [AVL_ADDR_W-1:0] load_addr;
   logic [AVL_DATA_W-1:0] load_wdata;

   logic                  waitrequest_q;
   logic                  stage_full;
   logic                  stage_wait;
   logic                  wait_rise;
   logic [CNT_W-1:0]      hold_cnt;
   logic                  hold_active;

   assign stage_full  = cmd_read | cmd_write;
   assign hold_active = (hold_cnt != '0);

   // Command leaves the stage this cycle
   assign cmd_issue = stage_full & ~hold_active & ~busy_stall;

   // Stage occupied and stuck, so it cannot load
   assign stage_wait = stage_full & ~cmd_issue;

   // Bus still sees waitrequest low this cycle, but the stage is stuck
   // The transfer on the bus is accepted and must go to the skid
   assign wait_rise = ~waitrequest_q & stage_wait;

   assign avl_csr_waitrequest = waitrequest_q;

   // Control flags of the skid and the registered waitrequest
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         waitrequest_q <= 1'b1;
         use_skid      <= 1'b1;
         skid_read     <= 1'b0;
         skid_write    <= 1'b0;
      end else begin
         waitrequest_q <= stage_wait;
         if (wait_rise) begin
            skid_read  <= avl_csr_read;
            skid_write <= avl_csr_write;
         end
         // Skid drained once the stage takes from it
         if (!stage_wait) begin
            use_skid <= 1'b0;
         end else if (wait_rise) begin
            use_skid <= 1'b1;
         end
      end
   end

   // Skid payload
   always_ff @(posedge clk) begin
      if (wait_rise) begin
         skid_addr  <= avl_csr_addr;
         skid_wdata <= avl_csr_wdata;
      end
   end

   // Skid has priority over the bus while it holds a request
   always_comb begin
      load_read  = avl_csr_read;
      load_write = avl_csr_write;
      load_addr  = avl_csr_addr;
      load_wdata = avl_csr_wdata;
      if (use_skid) begin
         load_read  = skid_read;
         load_write = skid_write;
         load_addr  = skid_addr;
         load_wdata = skid_wdata;
      end
   end

   // Command stage, loads when empty or issuing
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cmd_read  <= 1'b0;
         cmd_write <= 1'b0;
      end else if (!stage_wait) begin
         cmd_read  <= load_read;
         cmd_write <= load_write;
      end
   end

   always_ff @(posedge clk) begin
      if (!stage_wait) begin
         cmd_addr  <= load_addr;
         cmd_wdata <= load_wdata;
      end
   end

   // Post-issue hold, counts down from HOLD_CYCLES
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         hold_cnt <= '0;
      end else if (cmd_issue) begin
         hold_cnt <= CNT_W'(HOLD_CYCLES);
      end else if (hold_active) begin
         hold_cnt <= hold_cnt - 1'b1;
      end
   end

endmodule : avl_cmd_pipeline

/* rtl/ru_command_issue.sv */
// Turns an issued command into the remote-update core's strobes. Decodes the
// register index, maps it to a parameter code, generates the watchdog reset
// pulse and keeps the sticky reconfigure request. Strobes are combinational
// and appear in the issue cycle.

`timescale 1ns/1ps

module ru_command_issue
   import ru_avl_pkg::*;
   import ru_csr_pkg::*;
#(
   parameter int IN_DATA_WIDTH = 32
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     cmd_read,
   input  logic                     cmd_write,
   input  ru_addr_u                 cmd_addr,
   input  logic [AVL_DATA_W-1:0]    cmd_wdata,
   input  logic                     cmd_issue,
   output logic                     ru_read_param,
   output logic                     ru_write_param,
   output ru_param_t                ru_param,
   output logic [1:0]               ru_read_source,
   output logic [IN_DATA_WIDTH-1:0] ru_data_in,
   output logic                     ru_reset_timer,
   output logic                     ru_reconfig
);

   logic is_control;
   logic ctrl_set;
   logic reset_timer_op;
   logic reconfig_op;
   logic reconfig_q;

   // Control register seen through the control view
   assign is_control     = (cmd_addr.ctrl.index == CSR_CONTROL);
   assign reset_timer_op = (cmd_addr.ctrl.control_op == CTRL_RESET_TIMER);
   assign reconfig_op    = (cmd_addr.ctrl.control_op == CTRL_RECONFIG);

   // Write of a 1 to a control operation
   // Bit 0 is the only meaningful data bit here
   assign ctrl_set = cmd_issue & cmd_write & is_control & cmd_wdata[0];

   // Parameter view drives the code and the read source
   assign ru_param       = csr_to_param(cmd_addr.param.index);
   assign ru_read_source = cmd_addr.param.read_source;
   assign ru_data_in     = cmd_wdata[IN_DATA_WIDTH-1:0];

   // Reads pass to the core for every index
   assign ru_read_param = cmd_issue & cmd_read;

   // CSR_CONTROL is local, never a parameter write
   assign ru_write_param = cmd_issue & cmd_write & ~is_control;

   // One-cycle watchdog reset, direct to the core
   assign ru_reset_timer = ctrl_set & reset_timer_op;

   // Reconfigure request stays up until reset
   // The core reloads the device, so it is never withdrawn
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         reconfig_q <= 1'b0;
      end else if (ctrl_set && reconfig_op) begin
         reconfig_q <= 1'b1;
      end
   end

   assign ru_reconfig = reconfig_q;

endmodule : ru_command_issue

/* rtl/ru_busy_tracker.sv */
// Watches the core's busy signal. Stalls command issue while the core is busy
// and for the cycle after busy drops, and returns read data to the Avalon side
// on that cycle when the last parameter access was a read.

`timescale 1ns/1ps

module ru_busy_tracker
   import ru_avl_pkg::*;
#(
   parameter int OUT_DATA_WIDTH = 32
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      ru_busy,
   input  logic                      ru_read_param,
   input  logic                      ru_write_param,
   input  logic [OUT_DATA_WIDTH-1:0] ru_data_out,
   output logic                      busy_stall,
   output logic                      avl_csr_readdatavalid,
   output logic [AVL_DATA_W-1:0]     avl_csr_rdata
);

   logic busy_q;
   logic busy_fall;
   logic need_response;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         busy_q <= 1'b0;
      end else begin
         busy_q <= ru_busy;
      end
   end

   // First cycle with busy low again
   assign busy_fall = busy_q & ~ru_busy;

   // Extra cycle keeps issue off while the core presents its data
   assign busy_stall = ru_busy | busy_fall;

   // Pending read response, strobes never coincide
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         need_response <= 1'b0;
      end else if (ru_read_param) begin
         need_response <= 1'b1;
      end else if (ru_write_param) begin
         need_response <= 1'b0;
      end
   end

   assign avl_csr_readdatavalid = busy_fall & need_response;

   // Zero-extended core data, valid with readdatavalid only
   assign avl_csr_rdata = AVL_DATA_W'(ru_data_out);

endmodule : ru_busy_tracker

/* rtl/ru_update_top.sv */
// Remote-update controller. Bridges an Avalon-MM CSR slave to the
// parameter and control handshake of the configuration-update core.
// Instantiate with the core's data widths and the wanted post-issue hold.

`timescale 1ns/1ps

module ru_update_top
   import ru_avl_pkg::*;
   import ru_csr_pkg::*;
#(
   parameter int IN_DATA_WIDTH  = 32,
   parameter int OUT_DATA_WIDTH = 32,
   parameter int HOLD_CYCLES    = DEFAULT_HOLD_CYCLES
) (
   input  logic                      clk,
   input  logic                      reset,
   // Avalon-MM CSR slave
   input  logic                      avl_csr_write,
   input  logic                      avl_csr_read,
   input  logic [AVL_ADDR_W-1:0]     avl_csr_addr,
   input  logic [AVL_DATA_W-1:0]     avl_csr_wdata,
   output logic [AVL_DATA_W-1:0]     avl_csr_rdata,
   output logic                      avl_csr_readdatavalid,
   output logic                      avl_csr_waitrequest,
   // Remote-update core
   output logic [1:0]                ru_read_source,
   output logic                      ru_read_param,
   output logic                      ru_write_param,
   output ru_param_t                 ru_param,
   output logic                      ru_reconfig,
   output logic                      ru_reset_timer,
   output logic [IN_DATA_WIDTH-1:0]  ru_data_in,
   input  logic                      ru_busy,
   input  logic [OUT_DATA_WIDTH-1:0] ru_data_out
);

   // Command stage
   logic                  cmd_read;
   logic                  cmd_write;
   ru_addr_u              cmd_addr;
   logic [AVL_DATA_W-1:0] cmd_wdata;
   logic                  cmd_issue;

   // Issue blocked by the core
   logic                  busy_stall;

   avl_cmd_pipeline #(
      .HOLD_CYCLES (HOLD_CYCLES)
   ) i_cmd_pipeline (
      .clk                 (clk),
      .reset               (reset),
      .avl_csr_read        (avl_csr_read),
      .avl_csr_write       (avl_csr_write),
      .avl_csr_addr        (avl_csr_addr),
      .avl_csr_wdata       (avl_csr_wdata),
      .busy_stall          (busy_stall),
      .avl_csr_waitrequest (avl_csr_waitrequest),
      .cmd_read            (cmd_read),
      .cmd_write           (cmd_write),
      .cmd_addr            (cmd_addr),
      .cmd_wdata           (cmd_wdata),
      .cmd_issue           (cmd_issue)
   );

   ru_command_issue #(
      .IN_DATA_WIDTH (IN_DATA_WIDTH)
   ) i_command_issue (
      .clk            (clk),
      .reset          (reset),
      .cmd_read       (cmd_read),
      .cmd_write      (cmd_write),
      .cmd_addr       (cmd_addr),
      .cmd_wdata      (cmd_wdata),
      .cmd_issue      (cmd_issue),
      .ru_read_param  (ru_read_param),
      .ru_write_param (ru_write_param),
      .ru_param       (ru_param),
      .ru_read_source (ru_read_source),
      .ru_data_in     (ru_data_in),
      .ru_reset_timer (ru_reset_timer),
      .ru_reconfig    (ru_reconfig)
   );

   ru_busy_tracker #(
      .OUT_DATA_WIDTH (OUT_DATA_WIDTH)
   ) i_busy_tracker (
      .clk                   (clk),
      .reset                 (reset),
      .ru_busy               (ru_busy),
      .ru_read_param         (ru_read_param),
      .ru_write_param        (ru_write_param),
      .ru_data_out           (ru_data_out),
      .busy_stall            (busy_stall),
      .avl_csr_readdatavalid (avl_csr_readdatavalid),
      .avl_csr_rdata         (avl_csr_rdata)
   );

endmodule : ru_update_top

/* testbench/ru_update_assertions.sv */
// Concurrent checks on the core-side handshake of the remote-update
// controller. Bound to every ru_update_top instance.

`timescale 1ns/1ps

module ru_update_assertions (
   input logic clk,
   input logic reset,
   input logic ru_read_param,
   input logic ru_write_param,
   input logic ru_reset_timer,
   input logic ru_busy,
   input logic avl_csr_readdatavalid,
   input logic ru_reconfig
);

   // Read and write strobes are exclusive
   assert property (@(posedge clk) disable iff (reset)
      !(ru_read_param && ru_write_param))
      else $error("read and write strobes high together");

   // Nothing reaches a busy core
   assert property (@(posedge clk) disable iff (reset)
      (ru_read_param || ru_write_param || ru_reset_timer) |-> !ru_busy)
      else $error("core strobe while ru_busy is high");

   // Read data only on the first cycle after busy
   assert property (@(posedge clk) disable iff (reset)
      avl_csr_readdatavalid |-> ($past(ru_busy) && !ru_busy))
      else $error("readdatavalid without a falling ru_busy");

   // Sticky until reset
   assert property (@(posedge clk) disable iff (reset)
      !$fell(ru_reconfig))
      else $error("ru_reconfig fell outside reset");

endmodule : ru_update_assertions

bind ru_update_top ru_update_assertions i_assertions (
   .clk                   (clk),
   .reset                 (reset),
   .ru_read_param         (ru_read_param),
   .ru_write_param        (ru_write_param),
   .ru_reset_timer        (ru_reset_timer),
   .ru_busy               (ru_busy),
   .avl_csr_readdatavalid (avl_csr_readdatavalid),
   .ru_reconfig           (ru_reconfig)
);

/* testbench/ru_update_tb.sv */
// Self-checking testbench for the remote-update controller.
// Drives random Avalon-MM CSR transfers, models the core's busy and read data,
// and checks every core strobe and read response against a reference queue.

`timescale 1ns/1ps

module ru_update_tb
   import ru_csr_pkg::*;
();

   localparam int CLK_PERIOD  = 100;
   // 7 + 16 + 2 + 5 + 200 transfers over all tests
   localparam int NUM_XFERS   = 230;
   localparam int DRAIN_LIMIT = 200;
   // Kinds of expected core strobe
   localparam int K_READ  = 0;
   localparam int K_WRITE = 1;
   localparam int K_TIMER = 2;

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   logic        avl_csr_write = 1'b0;
   logic        avl_csr_read = 1'b0;
   logic [4:0]  avl_csr_addr = '0;
   logic [31:0] avl_csr_wdata = '0;
   logic [31:0] avl_csr_rdata;
   logic        avl_csr_readdatavalid;
   logic        avl_csr_waitrequest;
   logic [1:0]  ru_read_source;
   logic        ru_read_param;
   logic        ru_write_param;
   logic [2:0]  ru_param;
   logic        ru_reconfig;
   logic        ru_reset_timer;
   logic [31:0] ru_data_in;
   logic        ru_busy = 1'b0;
   logic [31:0] ru_data_out = '0;

   logic [31:0] rng_state = 32'hd8ed;
   int          err_count = 0;
   int          check_count = 0;
   int          test_num = 0;
   // Core model state
   int          busy_cnt = 0;
   logic [31:0] core_data = '0;
   logic        reconfig_exp = 1'b0;
   // Reference queues, word is {code, source, data}
   int          exp_kind[$];
   logic [36:0] exp_word[$];
   logic [31:0] rd_q[$];
   int          mon_kind;
   logic [36:0] mon_word;

   ru_update_top #(
      .IN_DATA_WIDTH  (32),
      .OUT_DATA_WIDTH (32),
      .HOLD_CYCLES    (2)
   ) i_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Index to core code, code 5 skipped
   function automatic logic [2:0] param_code(input logic [2:0] idx);
      if (idx == 3'd5) begin
         return 3'd6;
      end
      if (idx == 3'd6) begin
         return 3'd7;
      end
      return idx;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("error %s: got %h, expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic avl_transfer(input logic is_write, input logic [4:0] addr,
                               input logic [31:0] data);
      // Expected effect, queued in bus order
      if (!is_write) begin
         exp_kind.push_back(K_READ);
         exp_word.push_back({param_code(addr[4:2]), addr[1:0], 32'h0});
      end else if (addr[4:2] != CSR_CONTROL) begin
         exp_kind.push_back(K_WRITE);
         exp_word.push_back({param_code(addr[4:2]), 2'b00, data});
      end else if (data[0] && addr[1:0] == CTRL_RESET_TIMER) begin
         exp_kind.push_back(K_TIMER);
         exp_word.push_back('0);
      end else if (data[0] && addr[1:0] == CTRL_RECONFIG) begin
         reconfig_exp = 1'b1;
      end
      avl_csr_write = is_write;
      avl_csr_read  = !is_write;
      avl_csr_addr  = addr;
      avl_csr_wdata = data;
      // Taken by the next rising edge that sees waitrequest low
      while (avl_csr_waitrequest) begin
         @(negedge clk);
      end
      @(negedge clk);
      avl_csr_write = 1'b0;
      avl_csr_read  = 1'b0;
   endtask

   // Waits until all expected strobes and read data have been seen
   task automatic drain();
      int quiet;
      int waited;
      quiet  = 0;
      waited = 0;
      while (quiet < 6 && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
         if (exp_kind.size() == 0 && rd_q.size() == 0 && busy_cnt == 0) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
      if (quiet < 6) begin
         $display("Core strobes or read data still missing after %0d cycles", waited);
         err_count++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_num++;
      $display("test %0d %s: %0d errors", test_num, name, err_count - errs_before);
   endtask

   // Core model and strobe monitor, pre-edge values
   always @(posedge clk) begin
      if (reset) begin
         busy_cnt = 0;
      end else begin
         if (busy_cnt > 0) begin
            busy_cnt = busy_cnt - 1;
         end
         if (ru_read_param || ru_write_param || ru_reset_timer) begin
            if (exp_kind.size() == 0) begin
               $display("Core strobe seen with no command left in the reference model");
               err_count++;
            end else begin
               mon_kind = exp_kind.pop_front();
               mon_word = exp_word.pop_front();
               check_value("ru_read_param", ru_read_param, mon_kind == K_READ);
               check_value("ru_write_param", ru_write_param, mon_kind == K_WRITE);
               check_value("ru_reset_timer", ru_reset_timer, mon_kind == K_TIMER);
               if (mon_kind != K_TIMER) begin
                  check_value("ru_param", ru_param, mon_word[36:34]);
               end
               if (mon_kind == K_READ) begin
                  check_value("ru_read_source", ru_read_source, mon_word[33:32]);
               end
               if (mon_kind == K_WRITE) begin
                  check_value("ru_data_in", ru_data_in, mon_word[31:0]);
               end
            end
         end
         // Busy 1 to 8 cycles after a parameter strobe
         if (ru_read_param || ru_write_param) begin
            busy_cnt = 1 + int'(next_rand() % 8);
         end
         if (ru_read_param) begin
            core_data = next_rand();
            rd_q.push_back(core_data);
         end
         if (avl_csr_readdatavalid) begin
            if (rd_q.size() == 0) begin
               $display("Read data returned with no read outstanding");
               err_count++;
            end else begin
               check_value("avl_csr_rdata", avl_csr_rdata, rd_q.pop_front());
            end
         end
      end
   end

   always @(negedge clk) begin
      ru_busy     <= (busy_cnt > 0);
      ru_data_out <= core_data;
   end

   initial begin
      int errs;
      int waited;
      logic [2:0] idx;
      repeat (5) @(negedge clk);
      reset = 1'b0;

      errs = err_count;
      check_value("ru_read_param", ru_read_param, 0);
      check_value("ru_write_param", ru_write_param, 0);
      check_value("ru_reset_timer", ru_reset_timer, 0);
      check_value("avl_csr_readdatavalid", avl_csr_readdatavalid, 0);
      check_value("ru_reconfig", ru_reconfig, 0);
      waited = 0;
      while (avl_csr_waitrequest && waited < 2) begin
         @(negedge clk);
         waited++;
      end
      check_value("avl_csr_waitrequest", avl_csr_waitrequest, 0);
      end_test("reset state", errs);

      errs = err_count;
      for (int i = 0; i < 7; i++) begin
         avl_transfer(1'b1, {3'(i), 2'(next_rand())}, next_rand());
      end
      drain();
      end_test("parameter writes", errs);

      // One read in flight at a time
      errs = err_count;
      for (int i = 0; i < 16; i++) begin
         idx = 3'(next_rand() % 7);
         avl_transfer(1'b0, {idx, 2'(next_rand())}, 32'h0);
         drain();
      end
      end_test("parameter reads", errs);

      errs = err_count;
      avl_transfer(1'b1, {CSR_CONTROL, CTRL_RESET_TIMER}, next_rand() | 32'h1);
      avl_transfer(1'b1, {CSR_CONTROL, CTRL_RESET_TIMER}, next_rand() & ~32'h1);
      drain();
      end_test("watchdog reset", errs);

      errs = err_count;
      avl_transfer(1'b1, {CSR_WD_TIMEOUT, 2'd0}, next_rand());
      avl_transfer(1'b1, {CSR_CONTROL, CTRL_RECONFIG}, 32'h0);
      drain();
      check_value("ru_reconfig", ru_reconfig, 0);
      avl_transfer(1'b1, {CSR_CONTROL, CTRL_RECONFIG}, 32'h1);
      drain();
      check_value("ru_reconfig", ru_reconfig, 1);
      avl_transfer(1'b1, {CSR_BOOT_ADDRESS, 2'd0}, next_rand());
      avl_transfer(1'b1, {CSR_CONTROL, CTRL_RECONFIG}, 32'h0);
      drain();
      check_value("ru_reconfig", ru_reconfig, 1);
      end_test("reconfigure latch", errs);

      // Random mix with idle gaps, any control op
      errs = err_count;
      for (int i = 0; i < 200; i++) begin
         if (next_rand() % 2 == 1) begin
            avl_transfer(1'b1, 5'(next_rand()), next_rand());
         end else begin
            idx = 3'(next_rand() % 7);
            avl_transfer(1'b0, {idx, 2'(next_rand())}, 32'h0);
         end
         if (next_rand() % 4 == 0) begin
            @(negedge clk);
         end
      end
      drain();
      check_value("ru_reconfig", ru_reconfig, reconfig_exp);
      end_test("random mix", errs);

      $display("checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog, 40 cycles per transfer
   initial begin
      #(NUM_XFERS * 40 * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", NUM_XFERS * 40);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule : ru_update_tb

/* sim.f */
rtl/ru_avl_pkg.sv
rtl/ru_csr_pkg.sv
rtl/avl_cmd_pipeline.sv
rtl/ru_command_issue.sv
rtl/ru_busy_tracker.sv
rtl/ru_update_top.sv
testbench/ru_update_assertions.sv
testbench/ru_update_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the remote-update controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ru_update_tb -f sim.f
output="$(./obj_dir/Vru_update_tb)"
echo "$output"
if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
else
   exit 1
fi
